/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_xv_top
RTL_TOP   ?= xv_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
logic/xv_pkg.sv
logic/video_stage_if.sv
logic/video_timing.sv
logic/pixel_fetch.sv
logic/vram_arbiter.sv
logic/palette_out.sv
logic/bus_regs.sv
logic/xv_top.sv
sim/tb_xv_top.sv

/* logic/bus_regs.sv */
// even byte then odd byte; odd byte commits; strobes at least two cycles apart
`default_nettype none
`timescale 1ns/1ps

module bus_regs import xv_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_i,       // one cycle strobe
    input  wire logic       bus_rd_nwr_i,   // 1 read, 0 write
    input  wire reg_num_t   bus_reg_num_i,
    input  wire logic       bus_bytesel_i,  // 0 even (high), 1 odd (low)
    input  wire logic [7:0] bus_data_i,
    output logic [7:0]      bus_data_o,     // held until next read
    output logic            bus_intr_o,     // one cycle pulse
    output logic            cpu_wr_o,       // vram write strobe
    output word_t           cpu_addr_o,
    output word_t           cpu_data_o,
    output logic            pal_wr_o,       // palette write strobe
    output pix_index_t      pal_index_o,
    output rgb_t            pal_color_o,
    input  wire coord_t     line_i,         // current line
    input  wire logic       vblank_evt_i,
    input  wire logic       line_evt_i,
    output coord_t          line_cmp_o
);

    logic [7:0] hi_byte;                    // latched even byte
    word_t      vram_addr;
    pix_index_t pal_addr;
    intr_t      intr_mask;
    intr_t      intr_status;
    intr_t      intr_signal;
    intr_t      intr_clear;
    logic       wr_even;
    logic       wr_odd;
    logic       line_hit;

    assign wr_even = bus_cs_i && !bus_rd_nwr_i && !bus_bytesel_i;
    assign wr_odd  = bus_cs_i && !bus_rd_nwr_i && bus_bytesel_i;

    // drop a compare event made stale by a rewrite of LINE_CMP
    assign line_hit = line_evt_i && (line_i == line_cmp_o);

    always_comb begin
        intr_signal              = '0;
        intr_clear               = '0;
        intr_signal[INTR_VBLANK] = vblank_evt_i;
        intr_signal[INTR_LINE]   = line_hit;
        if (bus_reg_num_i == REG_INTR_CTRL) begin
            if (wr_even) begin
                intr_signal[3:2] = bus_data_i[3:2];     // cpu bits only
            end
            if (wr_odd) begin
                intr_clear = bus_data_i[3:0];
            end
        end
    end

    // register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cpu_wr_o   <= 1'b0;
            pal_wr_o   <= 1'b0;
            vram_addr  <= '0;
            pal_addr   <= '0;
            intr_mask  <= '0;
            line_cmp_o <= '0;
        end else begin
            cpu_wr_o <= 1'b0;
            pal_wr_o <= 1'b0;
            if (wr_odd) begin
                case (bus_reg_num_i)
                    REG_VRAM_ADDR: vram_addr <= {hi_byte, bus_data_i};
                    REG_VRAM_DATA: begin
                        cpu_wr_o  <= 1'b1;
                        vram_addr <= vram_addr + 1'b1;  // auto-increment
                    end
                    REG_PAL_ADDR:  pal_addr <= bus_data_i;
                    REG_PAL_DATA: begin
                        pal_wr_o <= 1'b1;
                        pal_addr <= pal_addr + 1'b1;
                    end
                    REG_INTR_MASK: intr_mask <= bus_data_i[3:0];
                    REG_LINE_CMP:  line_cmp_o <= {hi_byte[2:0], bus_data_i};
                    default: ;                          // ctrl handled above
                endcase
            end
        end
    end

    // write payloads, captured with the address before increment
    always_ff @(posedge clk) begin
        if (wr_even) begin
            hi_byte <= bus_data_i;
        end
        if (wr_odd) begin
            cpu_addr_o  <= vram_addr;
            cpu_data_o  <= {hi_byte, bus_data_i};
            pal_index_o <= pal_addr;
            pal_color_o <= {hi_byte[3:0], bus_data_i};
        end
    end

    // read-back, next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_data_o <= '0;
        end else if (bus_cs_i && bus_rd_nwr_i) begin
            case (bus_reg_num_i)
                REG_VRAM_ADDR: bus_data_o <= bus_bytesel_i ? vram_addr[7:0] : vram_addr[15:8];
                REG_INTR_MASK: bus_data_o <= bus_bytesel_i ? {4'h0, intr_status} : 8'h00;
                REG_LINE_CMP:  bus_data_o <= bus_bytesel_i ? line_cmp_o[7:0]
                                                           : {5'b0, line_cmp_o[10:8]};
                default:       bus_data_o <= 8'h00;
            endcase
        end
    end

    // interrupt pulse and status on the same edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_intr_o  <= 1'b0;
            intr_status <= '0;
        end else begin
            bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);  // new and unmasked
            intr_status <= (intr_status | intr_signal) & ~intr_clear;
        end
    end

    // cpu side must leave a gap between strobes
    a_strobe_gap: assert property (@(posedge clk) disable iff (reset_i)
        bus_cs_i |=> !bus_cs_i);

endmodule

`default_nettype wire

/* logic/palette_out.sv */
// 256 entry palette, two cycle latency, color forced black outside de
`default_nettype none
`timescale 1ns/1ps

module palette_out import xv_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    video_stage_if.dst      index_stage,    // from fetch
    input  wire logic       pal_wr_i,       // cpu palette write
    input  wire pix_index_t pal_index_i,
    input  wire rgb_t       pal_color_i,
    output logic [3:0]      red_o,
    output logic [3:0]      green_o,
    output logic [3:0]      blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

    rgb_t pal [256];
    rgb_t color;                            // lookup result
    logic hs_d;
    logic vs_d;
    logic de_d;

    // palette ram, sync read
    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal[pal_index_i] <= pal_color_i;
        end
        color <= pal[index_stage.payload];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_d    <= 1'b0;
            vs_d    <= 1'b0;
            de_d    <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
        end else begin
            hs_d    <= index_stage.hsync;   // match ram latency
            vs_d    <= index_stage.vsync;
            de_d    <= index_stage.de;
            hsync_o <= hs_d;
            vsync_o <= vs_d;
            dv_de_o <= de_d;
            red_o   <= de_d ? color.r : 4'h0;   // blank
            green_o <= de_d ? color.g : 4'h0;
            blue_o  <= de_d ? color.b : 4'h0;
        end
    end

endmodule

`default_nettype wire

/* logic/pixel_fetch.sv */
// H_VISIBLE must be even; reads one vram word per pixel pair, two cycle latency
`default_nettype none
`timescale 1ns/1ps

module pixel_fetch import xv_pkg::*; #(
    parameter  int H_VISIBLE = 16,
    parameter  int V_VISIBLE = 8,
    localparam int AW        = $clog2(H_VISIBLE * V_VISIBLE / 2)
) (
    input  wire logic        clk,
    input  wire logic        reset_i,
    video_stage_if.dst       coord_stage,   // from timing
    output logic             vid_rd_o,      // vram read request
    output logic [AW-1:0]    vid_addr_o,    // word address
    input  wire word_t       vid_data_i,    // valid cycle after vid_rd_o
    video_stage_if.src       index_stage    // to palette
);

    logic       hs_d;                       // stage 1 sync/de
    logic       vs_d;
    logic       de_d;
    logic       even_d;                     // read issued last cycle
    pix_index_t hi_byte;                    // odd pixel of the pair

    // request on even visible pixels only
    assign vid_rd_o   = coord_stage.de && !coord_stage.payload.h[0];
    assign vid_addr_o = AW'((int'(coord_stage.payload.v) * H_VISIBLE +
                             int'(coord_stage.payload.h)) >> 1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_d              <= 1'b0;
            vs_d              <= 1'b0;
            de_d              <= 1'b0;
            even_d            <= 1'b0;
            index_stage.hsync <= 1'b0;
            index_stage.vsync <= 1'b0;
            index_stage.de    <= 1'b0;
        end else begin
            hs_d              <= coord_stage.hsync;
            vs_d              <= coord_stage.vsync;
            de_d              <= coord_stage.de;
            even_d            <= vid_rd_o;
            index_stage.hsync <= hs_d;      // second delay stage
            index_stage.vsync <= vs_d;
            index_stage.de    <= de_d;
        end
    end

    // low byte now, high byte held for next pixel
    always_ff @(posedge clk) begin
        if (even_d) begin
            index_stage.payload <= vid_data_i[7:0];
            hi_byte             <= vid_data_i[15:8];
        end else begin
            index_stage.payload <= hi_byte;
        end
    end

endmodule

`default_nettype wire

/* logic/video_stage_if.sv */
// one video stage hop, no handshake, valid every cycle
`default_nettype none
`timescale 1ns/1ps

interface video_stage_if #(
    parameter type payload_t = logic        // coordinates or pixel index
) ();

    logic     hsync;                        // active high
    logic     vsync;                        // active high
    logic     de;                           // visible area
    payload_t payload;

    // driving stage
    modport src (
        output hsync,
        output vsync,
        output de,
        output payload
    );

    // receiving stage
    modport dst (
        input hsync,
        input vsync,
        input de,
        input payload
    );

endinterface

`default_nettype wire

/* logic/video_timing.sv */
// sync polarity active high; all outputs one cycle behind the counters
`default_nettype none
`timescale 1ns/1ps

module video_timing import xv_pkg::*; #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 2,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire coord_t line_cmp_i,         // line that fires line_evt_o
    video_stage_if.src  coord_stage,        // sync, de and x/y to fetch
    output coord_t      line_o,             // current line
    output logic        vblank_evt_o,       // first cycle of line V_VISIBLE
    output logic        line_evt_o          // first cycle of compare line
);

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    coord_t h_cnt;
    coord_t v_cnt;

    // pixel and line counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == coord_t'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == coord_t'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;  // frame wrap
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // control outputs, one cycle late
    always_ff @(posedge clk) begin
        if (reset_i) begin
            coord_stage.hsync <= 1'b0;
            coord_stage.vsync <= 1'b0;
            coord_stage.de    <= 1'b0;
            vblank_evt_o      <= 1'b0;
            line_evt_o        <= 1'b0;
        end else begin
            coord_stage.hsync <= (h_cnt >= coord_t'(H_VISIBLE + H_FRONT)) &&
                                 (h_cnt <  coord_t'(H_VISIBLE + H_FRONT + H_SYNC));
            coord_stage.vsync <= (v_cnt >= coord_t'(V_VISIBLE + V_FRONT)) &&
                                 (v_cnt <  coord_t'(V_VISIBLE + V_FRONT + V_SYNC));
            coord_stage.de    <= (h_cnt < coord_t'(H_VISIBLE)) && (v_cnt < coord_t'(V_VISIBLE));
            vblank_evt_o      <= (h_cnt == '0) && (v_cnt == coord_t'(V_VISIBLE));
            line_evt_o        <= (h_cnt == '0) && (v_cnt == line_cmp_i);
        end
    end

    // coordinates, aligned with de
    always_ff @(posedge clk) begin
        coord_stage.payload <= '{h: h_cnt, v: v_cnt};
        line_o              <= v_cnt;
    end

    // visible area never reaches into a sync interval
    a_de_no_sync: assert property (@(posedge clk) disable iff (reset_i)
        coord_stage.de |-> !coord_stage.hsync && !coord_stage.vsync);

endmodule

`default_nettype wire

/* logic/vram_arbiter.sv */
// DEPTH must be a power of two; cpu writes must be spaced so one pending entry suffices
`default_nettype none
`timescale 1ns/1ps

module vram_arbiter import xv_pkg::*; #(
    parameter  int DEPTH = 64,
    localparam int AW    = $clog2(DEPTH)
) (
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  wire logic          vid_rd_i,    // video read, always wins
    input  wire logic [AW-1:0] vid_addr_i,
    output word_t              vid_data_o,
    input  wire logic          cpu_wr_i,    // single cycle write strobe
    input  wire word_t         cpu_addr_i,  // wraps modulo DEPTH
    input  wire word_t         cpu_data_i
);

    word_t           mem [DEPTH];
    logic            pend_valid;            // write waiting for a free cycle
    logic [AW-1:0]   pend_addr;
    word_t           pend_data;
    logic            wr_en;
    logic [AW-1:0]   wr_addr;
    word_t           wr_data;

    // fresh strobe or held entry, only when video idle
    assign wr_en   = !vid_rd_i && (cpu_wr_i || pend_valid);
    assign wr_addr = cpu_wr_i ? cpu_addr_i[AW-1:0] : pend_addr;
    assign wr_data = cpu_wr_i ? cpu_data_i : pend_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= vid_rd_i && (pend_valid || cpu_wr_i);   // blocked, hold it
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_wr_i) begin
            pend_addr <= cpu_addr_i[AW-1:0];
            pend_data <= cpu_data_i;
        end
        if (vid_rd_i) begin
            vid_data_o <= mem[vid_addr_i];
        end
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one entry only, a second strobe would be lost
    a_no_overrun: assert property (@(posedge clk) disable iff (reset_i)
        cpu_wr_i |-> !pend_valid);

endmodule

`default_nettype wire

/* logic/xv_pkg.sv */
// shared types and register map; VRAM word holds two pixel indices, low byte first
package xv_pkg;

    typedef logic [2:0] reg_num_t;          // cpu register number

    localparam reg_num_t REG_VRAM_ADDR = 3'd0;   // vram word address, auto-increments
    localparam reg_num_t REG_VRAM_DATA = 3'd1;   // vram write data
    localparam reg_num_t REG_PAL_ADDR  = 3'd2;   // palette index, auto-increments
    localparam reg_num_t REG_PAL_DATA  = 3'd3;   // palette color, 12 bits
    localparam reg_num_t REG_INTR_MASK = 3'd4;   // mask write, status read on odd byte
    localparam reg_num_t REG_INTR_CTRL = 3'd5;   // even byte signals, odd byte clears
    localparam reg_num_t REG_LINE_CMP  = 3'd6;   // line compare value

    typedef logic [15:0] word_t;            // vram word
    typedef logic [7:0]  pix_index_t;       // palette index

    // red in upper bits
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef logic [10:0] coord_t;           // pixel or line counter

    typedef struct packed {
        coord_t h;
        coord_t v;
    } xy_t;

    typedef logic [3:0] intr_t;

    localparam int INTR_VBLANK = 0;         // start of vblank
    localparam int INTR_LINE   = 1;         // line compare hit
    // bits 2 and 3 only set by cpu writes

endpackage

/* logic/xv_top.sv */
// H_VISIBLE even and H_VISIBLE*V_VISIBLE/2 a power of two; pins lag counters by 5 cycles
`default_nettype none
`timescale 1ns/1ps

module xv_top import xv_pkg::*; #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 2,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_i,
    input  wire logic       bus_rd_nwr_i,
    input  wire reg_num_t   bus_reg_num_i,
    input  wire logic       bus_bytesel_i,
    input  wire logic [7:0] bus_data_i,
    output logic [7:0]      bus_data_o,
    output logic            bus_intr_o,
    output logic [3:0]      red_o,
    output logic [3:0]      green_o,
    output logic [3:0]      blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

    localparam int DEPTH = H_VISIBLE * V_VISIBLE / 2;  // one word per pixel pair
    localparam int AW    = $clog2(DEPTH);

    video_stage_if #(.payload_t(xy_t))        coord_stage ();   // timing to fetch
    video_stage_if #(.payload_t(pix_index_t)) index_stage ();   // fetch to palette

    logic          vid_rd;
    logic [AW-1:0] vid_addr;
    word_t         vid_data;
    logic          cpu_wr;
    word_t         cpu_addr;
    word_t         cpu_data;
    logic          pal_wr;
    pix_index_t    pal_index;
    rgb_t          pal_color;
    coord_t        line;
    coord_t        line_cmp;
    logic          vblank_evt;
    logic          line_evt;

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) video_timing_inst (
        .clk, .reset_i, .line_cmp_i(line_cmp), .coord_stage(coord_stage.src),
        .line_o(line), .vblank_evt_o(vblank_evt), .line_evt_o(line_evt)
    );

    pixel_fetch #(.H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)) pixel_fetch_inst (
        .clk, .reset_i, .coord_stage(coord_stage.dst), .vid_rd_o(vid_rd),
        .vid_addr_o(vid_addr), .vid_data_i(vid_data), .index_stage(index_stage.src)
    );

    vram_arbiter #(.DEPTH(DEPTH)) vram_arbiter_inst (
        .clk, .reset_i, .vid_rd_i(vid_rd), .vid_addr_i(vid_addr), .vid_data_o(vid_data),
        .cpu_wr_i(cpu_wr), .cpu_addr_i(cpu_addr), .cpu_data_i(cpu_data)
    );

    palette_out palette_out_inst (
        .clk, .reset_i, .index_stage(index_stage.dst), .pal_wr_i(pal_wr),
        .pal_index_i(pal_index), .pal_color_i(pal_color), .red_o, .green_o, .blue_o,
        .hsync_o, .vsync_o, .dv_de_o
    );

    bus_regs bus_regs_inst (
        .clk, .reset_i, .bus_cs_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i,
        .bus_data_i, .bus_data_o, .bus_intr_o,
        .cpu_wr_o(cpu_wr), .cpu_addr_o(cpu_addr), .cpu_data_o(cpu_data),
        .pal_wr_o(pal_wr), .pal_index_o(pal_index), .pal_color_o(pal_color),
        .line_i(line), .vblank_evt_i(vblank_evt), .line_evt_i(line_evt),
        .line_cmp_o(line_cmp)
    );

endmodule

`default_nettype wire

/* sim/tb_xv_top.sv */
// trace-driven testbench, default timing only; run from project root so sim/xv_trace.txt is found
`timescale 1ns/1ps

module tb_xv_top;

    import xv_pkg::*;

    localparam int H_VISIBLE = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 4;
    localparam int H_BACK    = 2;
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int DEPTH     = H_VISIBLE * V_VISIBLE / 2;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       bus_cs_i;
    logic       bus_rd_nwr_i;
    reg_num_t   bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic       bus_intr_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    // reference models
    word_t      vram_model [DEPTH];
    rgb_t       pal_model [256];
    word_t      vram_addr_model;
    pix_index_t pal_addr_model;
    logic [7:0] hi_model;                   // last even byte written
    logic [31:0] lfsr = 32'h3952_f2c8;
    int          intr_count = 0;            // pulses seen so far
    int          limit = 0;                 // watchdog cycles, 0 until trace is read

    // trace contents
    int op_q [$];
    int reg_q [$];
    int sel_q [$];
    int data_q [$];
    int exp_q [$];

    xv_top #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) xv_top_inst (
        .clk, .reset_i, .bus_cs_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i,
        .bus_data_i, .bus_data_o, .bus_intr_o, .red_o, .green_o, .blue_o,
        .hsync_o, .vsync_o, .dv_de_o
    );

    always #5 clk = ~clk;                   // 10 ns period

    // pulse counter, sampled away from the driving edge
    always @(negedge clk) begin
        if (!reset_i && bus_intr_o) begin
            intr_count <= intr_count + 1;
        end
    end

    // watchdog, armed once the trace length is known
    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("Timeout: the trace did not finish within %0d cycles", limit);
        $display("Test failed");
        $fatal(1);
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // register side effects, from the bus protocol
    task automatic model_write(input reg_num_t rn, input logic sel, input logic [7:0] d);
        if (!sel) begin
            hi_model = d;
        end else begin
            case (rn)
                REG_VRAM_ADDR: vram_addr_model = {hi_model, d};
                REG_VRAM_DATA: begin
                    vram_model[vram_addr_model % DEPTH] = {hi_model, d};
                    vram_addr_model = vram_addr_model + 1'b1;
                end
                REG_PAL_ADDR:  pal_addr_model = d;
                REG_PAL_DATA: begin
                    pal_model[pal_addr_model] = {hi_model[3:0], d};
                    pal_addr_model = pal_addr_model + 1'b1;
                end
                default: ;
            endcase
        end
    endtask

    // one write strobe, then one idle cycle
    task automatic bus_write(input reg_num_t rn, input logic sel, input logic [7:0] d);
        @(posedge clk);
        bus_cs_i      <= 1'b1;
        bus_rd_nwr_i  <= 1'b0;
        bus_reg_num_i <= rn;
        bus_bytesel_i <= sel;
        bus_data_i    <= d;
        @(posedge clk);
        bus_cs_i      <= 1'b0;
        model_write(rn, sel, d);
    endtask

    // data valid after the edge that samples the strobe
    task automatic bus_read(input reg_num_t rn, input logic sel, output logic [7:0] d);
        @(posedge clk);
        bus_cs_i      <= 1'b1;
        bus_rd_nwr_i  <= 1'b1;
        bus_reg_num_i <= rn;
        bus_bytesel_i <= sel;
        @(posedge clk);
        bus_cs_i      <= 1'b0;
        @(posedge clk);
        d = bus_data_o;                     // held since last edge
    endtask

    task automatic fill_palette();
        logic [15:0] c;
        for (int i = 0; i < 256; i++) begin
            rand_bits(12, c);
            bus_write(REG_PAL_DATA, 1'b0, {4'h0, c[11:8]});
            bus_write(REG_PAL_DATA, 1'b1, c[7:0]);
        end
    endtask

    task automatic fill_vram();
        logic [15:0] w;
        for (int i = 0; i < DEPTH; i++) begin
            rand_bits(16, w);
            bus_write(REG_VRAM_DATA, 1'b0, w[15:8]);
            bus_write(REG_VRAM_DATA, 1'b1, w[7:0]);
        end
    endtask

    // one frame from vsync rise to vsync rise, pixels against the models
    task automatic check_frame(input string name);
        logic       vs_prev;
        logic       hs_prev;
        int         k;
        int         hs_rises;
        int         vs_cycles;
        pix_index_t idx;
        word_t      w;
        vs_prev = 1'b1;
        @(negedge clk);
        while (!(vsync_o && !vs_prev)) begin
            vs_prev = vsync_o;
            @(negedge clk);
        end
        vs_prev   = 1'b1;
        hs_prev   = hsync_o;
        hs_rises  = 0;
        vs_cycles = 1;                      // the rising cycle itself
        k         = 0;
        @(negedge clk);
        while (!(vsync_o && !vs_prev)) begin
            if (hsync_o && !hs_prev) hs_rises++;
            if (vsync_o) vs_cycles++;
            if (dv_de_o) begin
                w   = vram_model[(k / 2) % DEPTH];
                idx = (k % 2) ? w[15:8] : w[7:0];   // low byte first
                check($sformatf("%s pixel %0d", name, k), pal_model[idx],
                      {red_o, green_o, blue_o});
                k++;
            end else begin
                check($sformatf("%s blank", name), 0, {red_o, green_o, blue_o});
            end
            hs_prev = hsync_o;
            vs_prev = vsync_o;
            @(negedge clk);
        end
        check($sformatf("%s hsync count", name), V_TOTAL, hs_rises);
        check($sformatf("%s de count", name), H_VISIBLE * V_VISIBLE, k);
        check($sformatf("%s vsync length", name), V_SYNC * H_TOTAL, vs_cycles);
    endtask

    initial begin
        int          fd;
        int          n;
        int          op;
        int          rn;
        int          sel;
        int          dat;
        int          ex;
        int          frames;
        int          fills;
        int          base;
        string       line;
        string       name;
        logic [7:0]  rd;

        reset_i       = 1'b1;
        bus_cs_i      = 1'b0;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        vram_addr_model = '0;
        pal_addr_model  = '0;
        hi_model        = '0;

        fd = $fopen("sim/xv_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/xv_trace.txt");
            $display("Test failed");
            $fatal(1);
        end
        frames = 0;
        fills  = 0;
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %d %d %h %h", op, rn, sel, dat, ex);
                if (n == 5) begin
                    op_q.push_back(op);
                    reg_q.push_back(rn);
                    sel_q.push_back(sel);
                    data_q.push_back(dat);
                    exp_q.push_back(ex);
                    if (op == "F") frames++;
                    if (op == "P") fills += 256;
                    if (op == "V") fills += DEPTH;
                end
            end
        end
        $fclose(fd);
        // ops, fills at two strobes each, frames with slack for alignment
        limit = 20 + op_q.size() * 4 + fills * 8 + frames * H_TOTAL * V_TOTAL * 2;

        // outputs quiet through reset and just after
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check("reset de", 0, dv_de_o);
            check("reset intr", 0, bus_intr_o);
            check("reset rgb", 0, {red_o, green_o, blue_o});
        end
        @(posedge clk);
        reset_i <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check("post reset de", 0, dv_de_o);
            check("post reset intr", 0, bus_intr_o);
            check("post reset rgb", 0, {red_o, green_o, blue_o});
        end

        base = 0;
        for (int i = 0; i < op_q.size(); i++) begin
            name = $sformatf("trace op %0d", i);
            case (op_q[i])
                "W": bus_write(reg_num_t'(reg_q[i]), sel_q[i][0], data_q[i][7:0]);
                "R": begin
                    bus_read(reg_num_t'(reg_q[i]), sel_q[i][0], rd);
                    check(name, exp_q[i], rd);
                end
                "P": fill_palette();
                "V": fill_vram();
                "F": check_frame(name);
                "I": begin
                    bus_read(REG_INTR_MASK, 1'b1, rd);
                    check({name, " status"}, exp_q[i], rd);
                    check({name, " pulses"}, data_q[i], intr_count - base);
                    base = intr_count;      // counter is stable at the rising edge
                end
                default: begin
                    $display("Unknown opcode in trace at op %0d", i);
                    $display("Test failed");
                    $fatal(1);
                end
            endcase
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* sim/xv_trace.txt */
# op reg sel data expect, data and expect in hex; W write, R read and compare
# P fill palette, V fill vram, F check a frame, I check pulse count (data) and status (expect)
W 2 1 00 00
P 0 0 00 00
W 0 0 00 00
W 0 1 00 00
V 0 0 00 00
R 0 0 00 00
R 0 1 00 40
F 0 0 00 00
I 0 0 00 03
W 5 1 0f 00
W 4 1 01 00
F 0 0 00 00
I 0 0 01 03
W 5 1 0f 00
F 0 0 00 00
I 0 0 01 03
W 4 1 00 00
W 5 1 0f 00
F 0 0 00 00
I 0 0 00 03
W 4 1 04 00
W 5 1 0f 00
W 5 0 04 00
I 0 0 01 04
W 5 0 04 00
I 0 0 00 04
W 4 1 02 00
W 6 0 00 00
W 6 1 03 00
R 6 1 00 03
R 6 0 00 00
W 5 1 0f 00
F 0 0 00 00
I 0 0 01 03
